//--- files.f
source/petri_pkg.sv
source/transition_unit.sv
source/fire_arbiter.sv
source/marking_store.sv
source/petri_top.sv
tests/petri_properties.sv
tests/petri_checker.sv
tests/petri_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the Petri-net engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module petri_tb -f files.f -o petri_sim

./obj_dir/petri_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -qx "test passed" sim.log; then
        exit 0
fi
exit 1

//--- source/fire_arbiter.sv
`timescale 1ns/1ps

module fire_arbiter (
        input  logic                                               clk,
        input  logic                                               rst,
        input  logic                                               eval,
        input  logic [petri_pkg::NUM_TRANS-1:0]                    enabled,
        input  logic [petri_pkg::NUM_TRANS*petri_pkg::TOKEN_W-1:0] amounts,
        output logic                                               fire_valid,
        output logic [petri_pkg::TRANS_IDX_W-1:0]                  fire_index,
        output logic [petri_pkg::TOKEN_W-1:0]                      fire_amount
);

        logic [petri_pkg::NUM_TRANS-1:0]   survive;
        logic                              pick_valid;
        logic [petri_pkg::TRANS_IDX_W-1:0] pick_index;
        logic [petri_pkg::TOKEN_W-1:0]     pick_amount;

        // Drop a transition while any of its suppressors is enabled
        always_comb begin
                for (int t = 0; t < petri_pkg::NUM_TRANS; t++) begin
                        survive[t] = enabled[t] && !(|(petri_pkg::NET_SUPPRESS[t] & enabled));
                end
        end

        // Lowest surviving index wins
        always_comb begin
                pick_index  = '0;
                pick_amount = '0;
                for (int t = petri_pkg::NUM_TRANS - 1; t >= 0; t--) begin
                        if (survive[t]) begin
                                pick_index  = petri_pkg::TRANS_IDX_W'(t);
                                pick_amount = amounts[t*petri_pkg::TOKEN_W +: petri_pkg::TOKEN_W];
                        end
                end
        end

        assign pick_valid = |survive;

        always_ff @(posedge clk) begin
                if (rst) begin
                        fire_valid <= 1'b0;
                end else begin
                        fire_valid <= eval && pick_valid; // Only lives for the apply cycle
                end
        end

        always_ff @(posedge clk) begin
                if (eval) begin
                        fire_index  <= pick_index;
                        fire_amount <= pick_amount;
                end
        end

endmodule

//--- source/marking_store.sv
`timescale 1ns/1ps

module marking_store #(
        parameter int MAX_STEPS = 1000
) (
        input  logic                                                clk,
        input  logic                                                rst,
        input  logic                                                load_valid,
        output logic                                                load_ready,
        input  logic [petri_pkg::NUM_PLACES*petri_pkg::TOKEN_W-1:0] load_marking,
        output logic [petri_pkg::NUM_PLACES*petri_pkg::TOKEN_W-1:0] marking,
        output logic                                                eval,
        input  logic                                                fire_valid,
        input  logic [petri_pkg::TRANS_IDX_W-1:0]                   fire_index,
        input  logic [petri_pkg::TOKEN_W-1:0]                       fire_amount,
        output logic                                                result_valid,
        input  logic                                                result_ready,
        output logic [petri_pkg::NUM_PLACES*petri_pkg::TOKEN_W-1:0] result_marking,
        output logic [petri_pkg::STEP_W-1:0]                        result_steps,
        output logic                                                result_limit
);

        petri_pkg::run_state_e state;

        logic [petri_pkg::TOKEN_W-1:0] places      [petri_pkg::NUM_PLACES];
        logic [petri_pkg::TOKEN_W-1:0] next_places [petri_pkg::NUM_PLACES];
        logic [petri_pkg::STEP_W-1:0]  steps;
        logic [petri_pkg::STEP_W-1:0]  steps_next;
        logic                          limit;
        logic                          load_accept;
        logic                          result_accept;

        assign load_ready    = (state == petri_pkg::ST_IDLE);
        assign result_valid  = (state == petri_pkg::ST_DONE);
        assign eval          = (state == petri_pkg::ST_EVAL);
        assign load_accept   = load_valid && load_ready;
        assign result_accept = result_valid && result_ready;
        assign steps_next    = steps + 1'b1;

        for (genvar p = 0; p < petri_pkg::NUM_PLACES; p++) begin : g_flat
                assign marking[p*petri_pkg::TOKEN_W +: petri_pkg::TOKEN_W] = places[p];
        end

        assign result_marking = marking;
        assign result_steps   = steps;
        assign result_limit   = limit;

        // Subtract from inputs first, then add to outputs, wrapping at 256
        always_comb begin
                for (int p = 0; p < petri_pkg::NUM_PLACES; p++) begin
                        next_places[p] = places[p];
                        if (petri_pkg::NET_IN[fire_index][p]) begin
                                next_places[p] = next_places[p] - fire_amount;
                        end
                        if (petri_pkg::NET_OUT[fire_index][p]) begin
                                next_places[p] = next_places[p] + fire_amount;
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        state <= petri_pkg::ST_IDLE;
                        steps <= '0;
                        limit <= 1'b0;
                end else begin
                        case (state)
                        petri_pkg::ST_IDLE: begin
                                if (load_accept) begin
                                        state <= petri_pkg::ST_EVAL;
                                        steps <= '0;
                                        limit <= 1'b0;
                                end
                        end
                        petri_pkg::ST_EVAL: begin
                                state <= petri_pkg::ST_APPLY; // Arbiter registers its pick now
                        end
                        petri_pkg::ST_APPLY: begin
                                if (!fire_valid) begin
                                        state <= petri_pkg::ST_DONE; // Net is dead
                                end else begin
                                        steps <= steps_next;
                                        if (steps_next == petri_pkg::STEP_W'(MAX_STEPS)) begin
                                                state <= petri_pkg::ST_DONE;
                                                limit <= 1'b1;
                                        end else begin
                                                state <= petri_pkg::ST_EVAL;
                                        end
                                end
                        end
                        petri_pkg::ST_DONE: begin
                                if (result_accept) begin
                                        state <= petri_pkg::ST_IDLE;
                                end
                        end
                        default: state <= petri_pkg::ST_IDLE;
                        endcase
                end
        end

        // Token counts
        always_ff @(posedge clk) begin
                for (int p = 0; p < petri_pkg::NUM_PLACES; p++) begin
                        if (load_accept) begin
                                places[p] <= load_marking[p*petri_pkg::TOKEN_W +: petri_pkg::TOKEN_W];
                        end else if (state == petri_pkg::ST_APPLY && fire_valid) begin
                                places[p] <= next_places[p];
                        end
                end
        end

endmodule

//--- source/petri_pkg.sv
package petri_pkg;

        localparam int TOKEN_W    = 8;
        localparam int NUM_PLACES = 8;
        localparam int NUM_TRANS  = 6;
        localparam int STEP_W     = 16;

        localparam int TRANS_IDX_W = $clog2(NUM_TRANS); // Width of a transition index

        // Input places of each transition, bit p set for place p
        localparam logic [NUM_PLACES-1:0] NET_IN [NUM_TRANS] = '{
                8'b0000_0011,   // t0: p0, p1
                8'b0000_0100,   // t1: p2
                8'b0000_1000,   // t2: p3
                8'b0011_0000,   // t3: p4, p5
                8'b0100_1000,   // t4: p3, p6
                8'b1000_0000    // t5: p7
        };

        // Output places, same layout as NET_IN
        localparam logic [NUM_PLACES-1:0] NET_OUT [NUM_TRANS] = '{
                8'b0000_0100,   // t0 to p2
                8'b0001_1000,   // t1 to p3, p4
                8'b0010_0000,   // t2 to p5
                8'b0100_0000,   // t3 to p6
                8'b1000_0000,   // t4 to p7
                8'b0000_0011    // t5 to p0, p1
        };

        // Transitions whose enabling holds back the row's transition
        localparam logic [NUM_TRANS-1:0] NET_SUPPRESS [NUM_TRANS] = '{
                6'b00_0000,
                6'b00_0000,
                6'b01_0000,     // t2 waits while t4 is enabled
                6'b00_0000,
                6'b00_0000,
                6'b00_0000
        };

        // Engine run states
        typedef enum logic [1:0] {
                ST_IDLE,        // Waiting for a load
                ST_EVAL,        // Arbiter picks a firing
                ST_APPLY,       // Marking updated by the picked firing
                ST_DONE         // Result offered to the host
        } run_state_e;

endpackage

//--- source/petri_top.sv
`timescale 1ns/1ps

module petri_top #(
        parameter int MAX_STEPS = 1000
) (
        input  logic                                                clk,
        input  logic                                                rst,
        input  logic                                                load_valid,
        output logic                                                load_ready,
        input  logic [petri_pkg::NUM_PLACES*petri_pkg::TOKEN_W-1:0] load_marking,
        output logic                                                result_valid,
        input  logic                                                result_ready,
        output logic [petri_pkg::NUM_PLACES*petri_pkg::TOKEN_W-1:0] result_marking,
        output logic [petri_pkg::STEP_W-1:0]                        result_steps,
        output logic                                                result_limit
);

        logic [petri_pkg::NUM_PLACES*petri_pkg::TOKEN_W-1:0] marking;
        logic [petri_pkg::NUM_TRANS-1:0]                     enabled;
        logic [petri_pkg::NUM_TRANS*petri_pkg::TOKEN_W-1:0]  amounts;
        logic                                                eval;
        logic                                                fire_valid;
        logic [petri_pkg::TRANS_IDX_W-1:0]                   fire_index;
        logic [petri_pkg::TOKEN_W-1:0]                       fire_amount;

        marking_store #(
                .MAX_STEPS(MAX_STEPS)
        ) marking_store_i (
                .clk            (clk),
                .rst            (rst),
                .load_valid     (load_valid),
                .load_ready     (load_ready),
                .load_marking   (load_marking),
                .marking        (marking),
                .eval           (eval),
                .fire_valid     (fire_valid),
                .fire_index     (fire_index),
                .fire_amount    (fire_amount),
                .result_valid   (result_valid),
                .result_ready   (result_ready),
                .result_marking (result_marking),
                .result_steps   (result_steps),
                .result_limit   (result_limit)
        );

        // One unit per transition
        for (genvar t = 0; t < petri_pkg::NUM_TRANS; t++) begin : g_trans
                transition_unit #(
                        .TRANS_INDEX(t)
                ) transition_unit_i (
                        .marking (marking),
                        .enabled (enabled[t]),
                        .amount  (amounts[t*petri_pkg::TOKEN_W +: petri_pkg::TOKEN_W])
                );
        end

        fire_arbiter fire_arbiter_i (
                .clk         (clk),
                .rst         (rst),
                .eval        (eval),
                .enabled     (enabled),
                .amounts     (amounts),
                .fire_valid  (fire_valid),
                .fire_index  (fire_index),
                .fire_amount (fire_amount)
        );

endmodule

//--- source/transition_unit.sv
`timescale 1ns/1ps

module transition_unit #(
        parameter int TRANS_INDEX = 0
) (
        input  logic [petri_pkg::NUM_PLACES*petri_pkg::TOKEN_W-1:0] marking,
        output logic                                                enabled,
        output logic [petri_pkg::TOKEN_W-1:0]                       amount
);

        localparam logic [petri_pkg::NUM_PLACES-1:0] IN_MASK =
                petri_pkg::NET_IN[TRANS_INDEX];

        logic [petri_pkg::TOKEN_W-1:0] tokens [petri_pkg::NUM_PLACES];

        for (genvar p = 0; p < petri_pkg::NUM_PLACES; p++) begin : g_slice
                assign tokens[p] = marking[p*petri_pkg::TOKEN_W +: petri_pkg::TOKEN_W];
        end

        // Enabled when every input place is nonzero, batch is the smallest count
        always_comb begin
                enabled = 1'b1;
                amount  = '1;
                for (int p = 0; p < petri_pkg::NUM_PLACES; p++) begin
                        if (IN_MASK[p]) begin
                                if (tokens[p] == '0) begin
                                        enabled = 1'b0;
                                end
                                if (tokens[p] < amount) begin
                                        amount = tokens[p];
                                end
                        end
                end
                if (!enabled) begin
                        amount = '0; // Empty input place gives no batch
                end
        end

endmodule

//--- tests/petri_checker.sv
`timescale 1ns/1ps

module petri_checker #(
        parameter int MAX_STEPS = 1000
) (
        input  logic                                                clk,
        input  logic                                                rst,
        input  logic                                                load_valid,
        input  logic                                                load_ready,
        input  logic [petri_pkg::NUM_PLACES*petri_pkg::TOKEN_W-1:0] load_marking,
        input  logic                                                result_valid,
        input  logic                                                result_ready,
        input  logic [petri_pkg::NUM_PLACES*petri_pkg::TOKEN_W-1:0] result_marking,
        input  logic [petri_pkg::STEP_W-1:0]                        result_steps,
        input  logic                                                result_limit,
        output int                                                  error_count,
        output int                                                  result_count
);

        localparam int NP = petri_pkg::NUM_PLACES;
        localparam int NT = petri_pkg::NUM_TRANS;
        localparam int TW = petri_pkg::TOKEN_W;

        // Net as drawn, one place mask per transition
        localparam logic [NP-1:0] IN_PLACES  [NT] = '{8'h03, 8'h04, 8'h08, 8'h30, 8'h48, 8'h80};
        localparam logic [NP-1:0] OUT_PLACES [NT] = '{8'h04, 8'h18, 8'h20, 8'h40, 8'h80, 8'h03};
        localparam logic [NT-1:0] BLOCKERS   [NT] = '{6'h00, 6'h00, 6'h10, 6'h00, 6'h00, 6'h00};

        logic [NP*TW-1:0]                 exp_marking_q [$];
        logic [petri_pkg::STEP_W-1:0]     exp_steps_q   [$];
        logic                             exp_limit_q   [$];
        logic [NP*TW-1:0]                 model_marking;
        int                               model_steps;
        logic                             model_limit;
        logic [NP*TW-1:0]                 exp_marking;
        logic [petri_pkg::STEP_W-1:0]     exp_steps;
        logic                             exp_limit;
        int                               errors = 0;
        int                               results = 0;

        assign error_count  = errors;
        assign result_count = results;

        // Run the net from a start marking until dead or out of steps
        task automatic run_model(input logic [NP*TW-1:0] start, output logic [NP*TW-1:0] final_m,
                                 output int steps, output logic limit);
                logic [TW-1:0] pl  [NP];
                logic [TW-1:0] amt [NT];
                logic [NT-1:0] en;
                int            pick;
                logic          dead;
                for (int p = 0; p < NP; p++) pl[p] = start[p*TW +: TW];
                steps = 0;
                limit = 1'b0;
                dead  = 1'b0;
                while (!dead && !limit) begin
                        for (int t = 0; t < NT; t++) begin
                                en[t]  = 1'b1;
                                amt[t] = 8'hff;
                                for (int p = 0; p < NP; p++) begin
                                        if (IN_PLACES[t][p] && pl[p] == 8'd0) en[t] = 1'b0;
                                        if (IN_PLACES[t][p] && pl[p] < amt[t]) amt[t] = pl[p];
                                end
                        end
                        pick = -1;
                        for (int t = 0; t < NT; t++) begin
                                if (pick < 0 && en[t] && (BLOCKERS[t] & en) == '0) pick = t;
                        end
                        if (pick < 0) begin
                                dead = 1'b1;
                        end else begin
                                for (int p = 0; p < NP; p++) begin
                                        if (IN_PLACES[pick][p]) pl[p] = pl[p] - amt[pick];
                                end
                                for (int p = 0; p < NP; p++) begin
                                        if (OUT_PLACES[pick][p]) pl[p] = pl[p] + amt[pick];
                                end
                                steps++;
                                if (steps == MAX_STEPS) limit = 1'b1;
                        end
                end
                for (int p = 0; p < NP; p++) final_m[p*TW +: TW] = pl[p];
        endtask

        always @(posedge clk) begin
                if (!rst && load_valid && load_ready) begin
                        if (exp_marking_q.size() != 0) begin
                                $display("a load was accepted while a result was still pending");
                                errors++;
                        end
                        run_model(load_marking, model_marking, model_steps, model_limit);
                        exp_marking_q.push_back(model_marking);
                        exp_steps_q.push_back(petri_pkg::STEP_W'(model_steps));
                        exp_limit_q.push_back(model_limit);
                end
                if (!rst && result_valid && result_ready) begin
                        if (exp_marking_q.size() == 0) begin
                                $display("a result was handed over without an accepted load");
                                errors++;
                        end else begin
                                exp_marking = exp_marking_q.pop_front();
                                exp_steps   = exp_steps_q.pop_front();
                                exp_limit   = exp_limit_q.pop_front();
                                results++;
                                if (result_marking !== exp_marking) begin
                                        $display("ERR result_marking: got %h, expected %h",
                                                 result_marking, exp_marking);
                                        errors++;
                                end
                                if (result_steps !== exp_steps) begin
                                        $display("ERR result_steps: got %h, expected %h",
                                                 result_steps, exp_steps);
                                        errors++;
                                end
                                if (result_limit !== exp_limit) begin
                                        $display("ERR result_limit: got %h, expected %h",
                                                 result_limit, exp_limit);
                                        errors++;
                                end
                        end
                end
        end

endmodule

//--- tests/petri_properties.sv
`timescale 1ns/1ps

module petri_properties (
        input logic                                                clk,
        input logic                                                rst,
        input logic                                                load_ready,
        input logic                                                result_valid,
        input logic                                                result_ready,
        input logic [petri_pkg::NUM_PLACES*petri_pkg::TOKEN_W-1:0] result_marking,
        input logic [petri_pkg::STEP_W-1:0]                        result_steps,
        input logic                                                result_limit,
        input petri_pkg::run_state_e                               state
);

        int fail_count = 0; // Read by the testbench for its closing line

        // Only one side of the engine is open at a time
        handshake_exclusive: assert property (@(posedge clk) disable iff (rst)
                !(load_ready && result_valid))
        else begin
                $error("load_ready and result_valid are high together");
                fail_count++;
        end

        result_hold: assert property (@(posedge clk) disable iff (rst)
                (result_valid && !result_ready) |=> (result_valid && $stable(result_marking)
                        && $stable(result_steps) && $stable(result_limit)))
        else begin
                $error("result outputs changed while result_ready was low");
                fail_count++;
        end

        reset_to_idle: assert property (@(posedge clk) rst |=> state == petri_pkg::ST_IDLE)
        else begin
                $error("state is not idle after reset");
                fail_count++;
        end

endmodule

//--- tests/petri_tb.sv
`timescale 1ns/1ps

module petri_tb;

        localparam int MW           = petri_pkg::NUM_PLACES * petri_pkg::TOKEN_W;
        localparam int MAX_STEPS    = 40;
        localparam int RESET_CYCLES = 10;
        localparam int TABLE_ROWS   = 8;
        localparam int RANDOM_CASES = 8;
        localparam int NUM_CASES    = TABLE_ROWS + RANDOM_CASES;
        localparam int MAX_STALL    = 6;
        localparam int WATCHDOG_CYCLES =
                RESET_CYCLES + NUM_CASES * (2 * MAX_STEPS + 2 + MAX_STALL + 20);

        // Start markings, p7 in the top byte down to p0 in the bottom byte
        localparam logic [MW-1:0] TABLE_MARKING [TABLE_ROWS] = '{
                64'h0000_0000_0000_0000,        // Dead, all empty
                64'h0000_0000_0000_0005,        // Dead, only p0
                64'h0000_0000_0000_0503,        // Batch of 3 through t0
                64'h0000_0101_0002_0000,        // t1 and t3 both enabled
                64'h0001_0000_0200_0000,        // t2 held back by t4
                64'h00c8_0000_0000_0101,        // Live cycle, runs into the limit
                64'h0000_0000_64c8_0000,        // p3 wraps past 255
                64'h0107_0605_0403_0207
        };
        localparam int TABLE_STALL [TABLE_ROWS] = '{0, 2, 3, 0, 1, 4, 0, MAX_STALL};

        logic          clk;
        logic          rst;
        logic          load_valid;
        logic          load_ready;
        logic [MW-1:0] load_marking;
        logic          result_valid;
        logic          result_ready;
        logic [MW-1:0] result_marking;
        logic [15:0]   result_steps;
        logic          result_limit;
        int            error_count;
        int            result_count;
        int            assert_fails;
        integer        seed = 32'h46e2;

        petri_top #(
                .MAX_STEPS(MAX_STEPS)
        ) petri_top_i (
                .clk            (clk),
                .rst            (rst),
                .load_valid     (load_valid),
                .load_ready     (load_ready),
                .load_marking   (load_marking),
                .result_valid   (result_valid),
                .result_ready   (result_ready),
                .result_marking (result_marking),
                .result_steps   (result_steps),
                .result_limit   (result_limit)
        );

        petri_checker #(
                .MAX_STEPS(MAX_STEPS)
        ) petri_checker_i (
                .clk            (clk),
                .rst            (rst),
                .load_valid     (load_valid),
                .load_ready     (load_ready),
                .load_marking   (load_marking),
                .result_valid   (result_valid),
                .result_ready   (result_ready),
                .result_marking (result_marking),
                .result_steps   (result_steps),
                .result_limit   (result_limit),
                .error_count    (error_count),
                .result_count   (result_count)
        );

        bind marking_store petri_properties petri_properties_i (
                .clk            (clk),
                .rst            (rst),
                .load_ready     (load_ready),
                .result_valid   (result_valid),
                .result_ready   (result_ready),
                .result_marking (result_marking),
                .result_steps   (result_steps),
                .result_limit   (result_limit),
                .state          (state)
        );

        assign assert_fails = petri_top_i.marking_store_i.petri_properties_i.fail_count;

        initial begin
                clk = 1'b0;
                forever #20 clk = ~clk;
        end

        // One load, wait for the result, hold it back, then take it
        task automatic run_case(input logic [MW-1:0] marking, input int stall);
                load_marking <= marking;
                load_valid   <= 1'b1;
                @(posedge clk);
                while (!load_ready) @(posedge clk);
                load_valid <= 1'b0;
                @(posedge clk);
                while (!result_valid) @(posedge clk);
                for (int i = 0; i < stall; i++) begin
                        load_marking <= ~marking; // Stray load, must stay unaccepted
                        load_valid   <= 1'b1;
                        @(posedge clk);
                end
                load_valid   <= 1'b0;
                result_ready <= 1'b1;
                @(posedge clk);
                result_ready <= 1'b0;
        endtask

        initial begin
                logic [MW-1:0] rand_marking;
                int            rand_stall;
                int            total;
                rst          = 1'b1;
                load_valid   = 1'b0;
                load_marking = '0;
                result_ready = 1'b0;
                repeat (RESET_CYCLES) @(posedge clk);
                rst <= 1'b0;
                @(posedge clk);
                for (int i = 0; i < TABLE_ROWS; i++) run_case(TABLE_MARKING[i], TABLE_STALL[i]);
                for (int i = 0; i < RANDOM_CASES; i++) begin
                        for (int p = 0; p < petri_pkg::NUM_PLACES; p++) begin
                                rand_marking[p*8 +: 8] = 8'($random(seed) & 7);
                        end
                        rand_stall = $random(seed) & 3;
                        run_case(rand_marking, rand_stall);
                end
                repeat (2) @(posedge clk);
                total = error_count + assert_fails;
                if (result_count != NUM_CASES) total++;
                $display("errors: %0d, assertion failures: %0d, results checked: %0d of %0d",
                         error_count, assert_fails, result_count, NUM_CASES);
                if (total == 0) begin
                        $display("test passed");
                end else begin
                        $display("test failed");
                end
                $finish;
        end

        initial begin
                repeat (WATCHDOG_CYCLES) @(posedge clk);
                $display("timeout, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
                $display("test failed");
                $finish;
        end

endmodule
